//--- Makefile
# Verilator build and run of the hardware manager testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_hw_manager \
	  -f hw_manager.f --Mdir obj_dir -o tb_hw_manager
	./obj_dir/tb_hw_manager | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "Simulation reported failure"; exit 1)
	@echo "Simulation log shows a pass"

clean:
	rm -rf obj_dir $(LOG)

//--- hw_manager.f
source/hw_manager_pkg.sv
source/phase_timer.sv
source/fault_encoder.sv
source/status_reporter.sv
source/power_sequencer.sv
source/hw_manager_top.sv
testbench/tb_hw_manager.sv

//--- source/fault_encoder.sv
module fault_encoder (
  input  logic sys_en,
  input  logic lock_viol,
  input  logic ext_shutdown,
  input  logic integ_thresh_avg_oob,
  input  logic integ_window_oob,
  input  logic integ_en_oob,
  input  logic sys_en_oob,
  input  hw_manager_pkg::board_mask_t shutdown_sense,
  input  hw_manager_pkg::board_mask_t over_thresh,
  input  hw_manager_pkg::board_mask_t thresh_underflow,
  input  hw_manager_pkg::board_mask_t thresh_overflow,
  input  hw_manager_pkg::board_mask_t dac_boot_fail,
  input  hw_manager_pkg::board_mask_t adc_boot_fail,
  input  hw_manager_pkg::board_mask_t bad_dac_cmd,
  input  hw_manager_pkg::board_mask_t bad_adc_cmd,
  output logic                    pre_fault_valid,
  output logic                    boot_fault_valid,
  output logic                    run_fault_valid,
  output hw_manager_pkg::status_t pre_fault_code,
  output hw_manager_pkg::status_t boot_fault_code,
  output hw_manager_pkg::status_t run_fault_code,
  output hw_manager_pkg::board_t  pre_fault_board,
  output hw_manager_pkg::board_t  boot_fault_board,
  output hw_manager_pkg::board_t  run_fault_board
);

  // Lowest set board wins, 0 when none set
  function automatic hw_manager_pkg::board_t low_board(hw_manager_pkg::board_mask_t mask);
    hw_manager_pkg::board_t idx;
    idx = '0;
    for (int i = hw_manager_pkg::NUM_BOARDS - 1; i >= 0; i--) begin
      if (mask[i]) idx = hw_manager_pkg::board_t'(i);
    end
    return idx;
  endfunction

  // Configuration flags are system wide
  assign pre_fault_board = '0;
  assign pre_fault_valid = integ_thresh_avg_oob || integ_window_oob ||
                           integ_en_oob || sys_en_oob;

  always_comb begin
    if (integ_thresh_avg_oob)  pre_fault_code = hw_manager_pkg::STS_INTEG_THRESH_AVG_OOB;
    else if (integ_window_oob) pre_fault_code = hw_manager_pkg::STS_INTEG_WINDOW_OOB;
    else if (integ_en_oob)     pre_fault_code = hw_manager_pkg::STS_INTEG_EN_OOB;
    else if (sys_en_oob)       pre_fault_code = hw_manager_pkg::STS_SYS_EN_OOB;
    else                       pre_fault_code = hw_manager_pkg::STS_OK;
  end

  // DAC ahead of ADC
  always_comb begin
    boot_fault_valid = |{dac_boot_fail, adc_boot_fail};
    if (|dac_boot_fail) begin
      boot_fault_code  = hw_manager_pkg::STS_DAC_BOOT_FAIL;
      boot_fault_board = low_board(dac_boot_fail);
    end else begin
      boot_fault_code  = |adc_boot_fail ? hw_manager_pkg::STS_ADC_BOOT_FAIL
                                        : hw_manager_pkg::STS_OK;
      boot_fault_board = low_board(adc_boot_fail);
    end
  end

  always_comb begin
    run_fault_valid = 1'b1;
    run_fault_board = '0; // System wide unless a mask wins
    if (!sys_en) run_fault_code = hw_manager_pkg::STS_PS_SHUTDOWN;
    else if (lock_viol) run_fault_code = hw_manager_pkg::STS_LOCK_VIOL;
    else if (|shutdown_sense) begin
      run_fault_code  = hw_manager_pkg::STS_SHUTDOWN_SENSE;
      run_fault_board = low_board(shutdown_sense);
    end else if (ext_shutdown) run_fault_code = hw_manager_pkg::STS_EXT_SHUTDOWN;
    else if (|over_thresh) begin
      run_fault_code  = hw_manager_pkg::STS_OVER_THRESH;
      run_fault_board = low_board(over_thresh);
    end else if (|thresh_underflow) begin
      run_fault_code  = hw_manager_pkg::STS_THRESH_UNDERFLOW;
      run_fault_board = low_board(thresh_underflow);
    end else if (|thresh_overflow) begin
      run_fault_code  = hw_manager_pkg::STS_THRESH_OVERFLOW;
      run_fault_board = low_board(thresh_overflow);
    end else if (|bad_dac_cmd) begin
      run_fault_code  = hw_manager_pkg::STS_BAD_DAC_CMD;
      run_fault_board = low_board(bad_dac_cmd);
    end else if (|bad_adc_cmd) begin
      run_fault_code  = hw_manager_pkg::STS_BAD_ADC_CMD;
      run_fault_board = low_board(bad_adc_cmd);
    end else begin
      run_fault_valid = 1'b0;
      run_fault_code  = hw_manager_pkg::STS_OK;
    end
  end

  // Sequencer trusts the board only with its valid bit
  always_comb begin
    a_board_with_valid: assert ((boot_fault_board == '0 || boot_fault_valid) &&
                                (run_fault_board == '0 || run_fault_valid));
  end

endmodule

//--- source/hw_manager_pkg.sv
package hw_manager_pkg;

  // Sequencer states, encodings as software reads them back
  typedef enum logic [3:0] {
    ST_IDLE              = 4'd1,
    ST_CONFIRM_SPI_RST   = 4'd2,
    ST_RELEASE_SD_F      = 4'd3,
    ST_PULSE_SD_RST      = 4'd4,
    ST_SD_RST_DELAY      = 4'd5,
    ST_CONFIRM_SPI_START = 4'd6,
    ST_RUNNING           = 4'd7,
    ST_HALTED            = 4'd8
  } state_t;

  // Timed phases of the power-up sequence
  typedef enum logic [2:0] {
    PH_SPI_RST    = 3'd0, // SPI must come up off
    PH_FORCE_REL  = 3'd1, // Shutdown force released
    PH_RST_PULSE  = 3'd2, // Shutdown reset held low
    PH_RST_DELAY  = 3'd3, // Settle after reset pulse
    PH_SPI_START  = 3'd4  // SPI must start
  } phase_t;

  typedef logic [24:0] status_t;

  localparam int unsigned NUM_BOARDS = 8;
  typedef logic [NUM_BOARDS-1:0] board_mask_t; // One flag per board
  typedef logic [2:0]            board_t;      // Board index

  localparam int unsigned SPI_SETTLE_CYCLES = 10; // spi_off not trusted before this
  localparam int unsigned STATUS_WORD_W     = 32; // board + code + state

  // Basic system
  localparam status_t STS_OK          = 25'h0001;
  localparam status_t STS_PS_SHUTDOWN = 25'h0002;
  // SPI subsystem
  localparam status_t STS_SPI_START_TIMEOUT = 25'h0100;
  localparam status_t STS_SPI_INIT_TIMEOUT  = 25'h0101;
  // Pre-start configuration
  localparam status_t STS_INTEG_THRESH_AVG_OOB = 25'h0200;
  localparam status_t STS_INTEG_WINDOW_OOB     = 25'h0201;
  localparam status_t STS_INTEG_EN_OOB         = 25'h0202;
  localparam status_t STS_SYS_EN_OOB           = 25'h0203;
  localparam status_t STS_LOCK_VIOL            = 25'h0204;
  // Shutdown sense
  localparam status_t STS_SHUTDOWN_SENSE = 25'h0300;
  localparam status_t STS_EXT_SHUTDOWN   = 25'h0301;
  // Integrator threshold core
  localparam status_t STS_OVER_THRESH      = 25'h0400;
  localparam status_t STS_THRESH_UNDERFLOW = 25'h0401;
  localparam status_t STS_THRESH_OVERFLOW  = 25'h0402;
  // DAC and ADC channels
  localparam status_t STS_DAC_BOOT_FAIL = 25'h0600;
  localparam status_t STS_BAD_DAC_CMD   = 25'h0601;
  localparam status_t STS_ADC_BOOT_FAIL = 25'h0700; // Own code for ADC boot
  localparam status_t STS_BAD_ADC_CMD   = 25'h0701;

endpackage

//--- source/hw_manager_top.sv
module hw_manager_top #(
  // Cycle counts at 250 MHz
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25_000_000, // 100 ms
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25_000,     // 100 us
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25_000_000, // 100 ms
  parameter int unsigned SPI_RST_WAIT         = 25_000_000, // 100 ms
  parameter int unsigned SPI_START_WAIT       = 250_000_000 // 1 s
) (
  input  logic clk,
  input  logic aresetn,
  input  logic sys_en,
  input  logic spi_off,
  input  logic ext_shutdown,
  input  logic integ_thresh_avg_oob,
  input  logic integ_window_oob,
  input  logic integ_en_oob,
  input  logic sys_en_oob,
  input  logic lock_viol,
  input  logic irq_ack,
  input  hw_manager_pkg::board_mask_t shutdown_sense,
  input  hw_manager_pkg::board_mask_t over_thresh,
  input  hw_manager_pkg::board_mask_t thresh_underflow,
  input  hw_manager_pkg::board_mask_t thresh_overflow,
  input  hw_manager_pkg::board_mask_t dac_boot_fail,
  input  hw_manager_pkg::board_mask_t adc_boot_fail,
  input  hw_manager_pkg::board_mask_t bad_dac_cmd,
  input  hw_manager_pkg::board_mask_t bad_adc_cmd,
  output logic unlock_cfg,
  output logic spi_clk_power_n,
  output logic spi_en,
  output logic shutdown_sense_en,
  output logic block_buffers,
  output logic n_shutdown_force,
  output logic n_shutdown_rst,
  output logic irq_req,
  output logic [hw_manager_pkg::STATUS_WORD_W-1:0] status_word
);

  // Sequencer and timer
  logic                   timer_start, timer_settled, timer_expired;
  hw_manager_pkg::phase_t timer_phase;
  // Fault encoder results
  logic                    pre_fault_valid, boot_fault_valid, run_fault_valid;
  hw_manager_pkg::status_t pre_fault_code, boot_fault_code, run_fault_code;
  hw_manager_pkg::board_t  pre_fault_board, boot_fault_board, run_fault_board;
  // Sequencer and reporter
  logic                    capture, clear, notify, irq_done;
  hw_manager_pkg::status_t capture_code;
  hw_manager_pkg::board_t  capture_board;
  hw_manager_pkg::state_t  state;

  power_sequencer u_seq (.*);

  phase_timer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_RST_WAIT         (SPI_RST_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_timer (.*);

  fault_encoder u_faults (.*);

  status_reporter u_status (.*);

endmodule

//--- source/phase_timer.sv
module phase_timer #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25_000_000,
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25_000,
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25_000_000,
  parameter int unsigned SPI_RST_WAIT         = 25_000_000,
  parameter int unsigned SPI_START_WAIT       = 250_000_000
) (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   timer_start,
  input  hw_manager_pkg::phase_t timer_phase,
  output logic                   timer_settled,
  output logic                   timer_expired
);

  hw_manager_pkg::phase_t phase; // Phase being timed
  logic [31:0]            count;
  logic [31:0]            limit;

  // Limit of the latched phase
  always_comb begin
    case (phase)
      hw_manager_pkg::PH_SPI_RST:   limit = 32'(SPI_RST_WAIT);
      hw_manager_pkg::PH_FORCE_REL: limit = 32'(SHUTDOWN_FORCE_DELAY);
      hw_manager_pkg::PH_RST_PULSE: limit = 32'(SHUTDOWN_RESET_PULSE);
      hw_manager_pkg::PH_RST_DELAY: limit = 32'(SHUTDOWN_RESET_DELAY);
      default:                      limit = 32'(SPI_START_WAIT);
    endcase
  end

  assign timer_settled = count >= 32'(hw_manager_pkg::SPI_SETTLE_CYCLES);
  assign timer_expired = count >= limit;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      phase <= hw_manager_pkg::PH_SPI_RST;
      count <= '0;
    end else if (timer_start) begin
      phase <= timer_phase;
      count <= '0; // Cycle 0 of the new phase
    end else if (!(timer_expired && timer_settled)) begin
      count <= count + 32'd1; // Saturates once both flags hold
    end
  end

  a_phase_defined: assert property (@(posedge clk) disable iff (!aresetn)
    timer_start |-> timer_phase inside {hw_manager_pkg::PH_SPI_RST,
      hw_manager_pkg::PH_FORCE_REL, hw_manager_pkg::PH_RST_PULSE,
      hw_manager_pkg::PH_RST_DELAY, hw_manager_pkg::PH_SPI_START});

endmodule

//--- source/power_sequencer.sv
module power_sequencer (
  input  logic clk,
  input  logic aresetn,
  input  logic sys_en,
  input  logic spi_off,
  input  logic timer_settled,
  input  logic timer_expired,
  input  logic irq_done,
  input  logic pre_fault_valid,
  input  logic boot_fault_valid,
  input  logic run_fault_valid,
  input  hw_manager_pkg::status_t pre_fault_code,
  input  hw_manager_pkg::status_t boot_fault_code,
  input  hw_manager_pkg::status_t run_fault_code,
  input  hw_manager_pkg::board_t  pre_fault_board,
  input  hw_manager_pkg::board_t  boot_fault_board,
  input  hw_manager_pkg::board_t  run_fault_board,
  output logic                    timer_start,
  output hw_manager_pkg::phase_t  timer_phase,
  output logic                    capture,
  output logic                    clear,
  output logic                    notify,
  output hw_manager_pkg::status_t capture_code,
  output hw_manager_pkg::board_t  capture_board,
  output hw_manager_pkg::state_t  state,
  output logic unlock_cfg,
  output logic spi_clk_power_n,
  output logic spi_en,
  output logic shutdown_sense_en,
  output logic block_buffers,
  output logic n_shutdown_force,
  output logic n_shutdown_rst
);

  hw_manager_pkg::state_t state_next;

  // Next state, timer kick and halt cause
  always_comb begin
    state_next    = state;
    timer_start   = 1'b0;
    timer_phase   = hw_manager_pkg::PH_SPI_RST;
    capture_code  = hw_manager_pkg::STS_OK;
    capture_board = '0;
    case (state)
      hw_manager_pkg::ST_IDLE: begin
        if (sys_en && pre_fault_valid) begin // Bad config never unlocks
          state_next    = hw_manager_pkg::ST_HALTED;
          capture_code  = pre_fault_code;
          capture_board = pre_fault_board;
        end else if (sys_en) begin
          state_next  = hw_manager_pkg::ST_CONFIRM_SPI_RST;
          timer_start = 1'b1;
        end
      end
      hw_manager_pkg::ST_CONFIRM_SPI_RST: begin
        if (spi_off && timer_settled) begin
          state_next  = hw_manager_pkg::ST_RELEASE_SD_F;
          timer_start = 1'b1;
          timer_phase = hw_manager_pkg::PH_FORCE_REL;
        end else if (timer_expired) begin
          state_next   = hw_manager_pkg::ST_HALTED;
          capture_code = hw_manager_pkg::STS_SPI_INIT_TIMEOUT;
        end
      end
      hw_manager_pkg::ST_RELEASE_SD_F: begin
        if (timer_expired) begin
          state_next  = hw_manager_pkg::ST_PULSE_SD_RST;
          timer_start = 1'b1;
          timer_phase = hw_manager_pkg::PH_RST_PULSE;
        end
      end
      hw_manager_pkg::ST_PULSE_SD_RST: begin
        if (timer_expired) begin
          state_next  = hw_manager_pkg::ST_SD_RST_DELAY;
          timer_start = 1'b1;
          timer_phase = hw_manager_pkg::PH_RST_DELAY;
        end
      end
      hw_manager_pkg::ST_SD_RST_DELAY: begin
        if (timer_expired) begin
          state_next  = hw_manager_pkg::ST_CONFIRM_SPI_START;
          timer_start = 1'b1;
          timer_phase = hw_manager_pkg::PH_SPI_START;
        end
      end
      hw_manager_pkg::ST_CONFIRM_SPI_START: begin
        if (!spi_off) begin
          state_next = hw_manager_pkg::ST_RUNNING;
        end else if (boot_fault_valid) begin // Boot fault beats timeout
          state_next    = hw_manager_pkg::ST_HALTED;
          capture_code  = boot_fault_code;
          capture_board = boot_fault_board;
        end else if (timer_expired) begin
          state_next   = hw_manager_pkg::ST_HALTED;
          capture_code = hw_manager_pkg::STS_SPI_START_TIMEOUT;
        end
      end
      hw_manager_pkg::ST_RUNNING: begin
        if (run_fault_valid) begin
          state_next    = hw_manager_pkg::ST_HALTED;
          capture_code  = run_fault_code;
          capture_board = run_fault_board;
        end
      end
      hw_manager_pkg::ST_HALTED: begin
        if (!sys_en) state_next = hw_manager_pkg::ST_IDLE;
      end
      default: state_next = hw_manager_pkg::ST_HALTED; // Illegal code fails safe
    endcase
  end

  assign capture = (state_next == hw_manager_pkg::ST_HALTED) &&
                   (state != hw_manager_pkg::ST_HALTED);
  assign clear   = (state == hw_manager_pkg::ST_HALTED) && !sys_en;
  // Processor hears about run entry and every halt
  assign notify  = capture || ((state_next == hw_manager_pkg::ST_RUNNING) &&
                               (state != hw_manager_pkg::ST_RUNNING));

  // Power stage outputs change on the edge that changes state
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= hw_manager_pkg::ST_IDLE;
      unlock_cfg        <= 1'b1;
      spi_clk_power_n   <= 1'b1;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      block_buffers     <= 1'b1;
      n_shutdown_force  <= 1'b0;
      n_shutdown_rst    <= 1'b1;
    end else begin
      state <= state_next;
      if (state_next != state) begin
        case (state_next)
          hw_manager_pkg::ST_IDLE: unlock_cfg <= 1'b1;
          hw_manager_pkg::ST_CONFIRM_SPI_RST: begin
            unlock_cfg      <= 1'b0; // Lock config
            spi_clk_power_n <= 1'b0; // Clock SPI so it can report off
          end
          hw_manager_pkg::ST_RELEASE_SD_F: begin
            spi_clk_power_n  <= 1'b1;
            n_shutdown_force <= 1'b1;
          end
          hw_manager_pkg::ST_PULSE_SD_RST: n_shutdown_rst <= 1'b0;
          hw_manager_pkg::ST_SD_RST_DELAY: n_shutdown_rst <= 1'b1;
          hw_manager_pkg::ST_CONFIRM_SPI_START: begin
            shutdown_sense_en <= 1'b1;
            spi_clk_power_n   <= 1'b0;
            spi_en            <= 1'b1;
          end
          hw_manager_pkg::ST_RUNNING: block_buffers <= 1'b0;
          default: begin // Halt drives everything safe at once
            n_shutdown_force  <= 1'b0;
            n_shutdown_rst    <= 1'b1;
            shutdown_sense_en <= 1'b0;
            spi_clk_power_n   <= 1'b1;
            spi_en            <= 1'b0;
            block_buffers     <= 1'b1;
          end
        endcase
      end
    end
  end

  // Power stage reset only pulses with force released
  a_rst_needs_force: assert property (@(posedge clk) disable iff (!aresetn)
    !n_shutdown_rst |-> n_shutdown_force);
  a_spi_en_clocked: assert property (@(posedge clk) disable iff (!aresetn)
    spi_en |-> !spi_clk_power_n);

endmodule

//--- source/status_reporter.sv
module status_reporter (
  input  logic                    clk,
  input  logic                    aresetn,
  input  logic                    capture,
  input  logic                    clear,
  input  logic                    notify,
  input  logic                    irq_ack,
  input  hw_manager_pkg::status_t capture_code,
  input  hw_manager_pkg::board_t  capture_board,
  input  hw_manager_pkg::state_t  state,
  output logic [hw_manager_pkg::STATUS_WORD_W-1:0] status_word,
  output logic                    irq_req,
  output logic                    irq_done
);

  hw_manager_pkg::status_t code;
  hw_manager_pkg::board_t  board;
  logic                    irq_pend; // Notify arrived during open handshake
  logic                    ack_wait; // Waiting for ack to drop

  always_ff @(posedge clk) begin
    if (!aresetn || clear) begin
      code  <= hw_manager_pkg::STS_OK;
      board <= '0;
    end else if (capture) begin
      code  <= capture_code;
      board <= capture_board;
    end
  end

  assign status_word = {board, code, state}; // 3 + 25 + 4 bits

  // Four phase request toward the processor
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      irq_req  <= 1'b0;
      irq_pend <= 1'b0;
      ack_wait <= 1'b0;
      irq_done <= 1'b0;
    end else begin
      irq_done <= 1'b0;
      if (irq_req) begin
        if (irq_ack) begin
          irq_req  <= 1'b0;
          ack_wait <= 1'b1;
          irq_done <= 1'b1;
        end
        if (notify) irq_pend <= 1'b1;
      end else if (ack_wait) begin
        if (!irq_ack) ack_wait <= 1'b0;
        if (notify) irq_pend <= 1'b1;
      end else if (notify || irq_pend) begin
        irq_req  <= 1'b1; // Pending notifies merge into this one
        irq_pend <= 1'b0;
      end
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!aresetn)
    irq_req && !irq_ack |=> irq_req);

endmodule

//--- testbench/hw_manager_tests.txt
# kind cfg sys sense over_thresh underflow overflow dac_boot adc_boot bad_dac bad_adc code board
# cfg bits: 0 thresh avg, 1 window, 2 integ en, 3 sys_en oob / sys bits: 0 lock, 1 ext, 2 drop sys_en
clean     0 0 00 00 00 00 00 00 00 00 0001 0
cfg       1 0 00 00 00 00 00 00 00 00 0200 0
cfg       f 0 00 00 00 00 00 00 00 00 0200 0
cfg       6 0 00 00 00 00 00 00 00 00 0201 0
cfg       c 0 00 00 00 00 00 00 00 00 0202 0
cfg       8 0 00 00 00 00 00 00 00 00 0203 0
run       0 4 00 00 00 00 00 00 00 00 0002 0
run       0 7 ff 00 00 00 00 00 00 00 0002 0
run       0 1 10 00 00 00 00 00 00 00 0204 0
run       0 0 28 00 00 00 00 00 00 00 0300 3
run       0 2 00 01 00 00 00 00 00 00 0301 0
run       0 0 00 80 40 00 00 00 00 00 0400 7
run       0 0 00 00 06 00 00 00 00 00 0401 1
run       0 0 00 00 00 40 00 00 01 00 0402 6
run       0 0 00 00 00 00 00 00 10 08 0601 4
run       0 0 00 00 00 00 00 00 00 04 0701 2
spi_rst   0 0 00 00 00 00 00 00 00 00 0101 0
spi_start 0 0 00 00 00 00 00 00 00 00 0100 0
boot      0 0 00 00 00 00 20 00 00 00 0600 5
boot      0 0 00 00 00 00 00 0c 00 00 0700 2
boot      0 0 00 00 00 00 80 01 00 00 0600 7

//--- testbench/tb_hw_manager.sv
module tb_hw_manager;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned FORCE_DELAY = 40;
  localparam int unsigned RESET_PULSE = 8;
  localparam int unsigned RESET_DELAY = 40;
  localparam int unsigned RST_WAIT    = 60;
  localparam int unsigned START_WAIT  = 200;
  localparam int WAIT_LIMIT = 2000; // Cycles allowed for any one wait

  localparam logic [24:0] CODE_OK    = 25'h1;
  localparam logic [3:0]  ST_IDLE    = 4'd1;
  localparam logic [3:0]  ST_RUNNING = 4'd7;
  localparam logic [3:0]  ST_HALTED  = 4'd8;

  // Which DUT level a wait looks at
  localparam int SEL_FORCE  = 0;
  localparam int SEL_RST    = 1;
  localparam int SEL_SPI_EN = 2;
  localparam int SEL_BLOCK  = 3;
  localparam int SEL_REQ    = 4;
  localparam int SEL_ACK    = 5;
  localparam int SEL_HALTED = 6;
  localparam int SEL_IDLE   = 7;

  // SPI stand in behaviour
  localparam logic [1:0] SPI_NORMAL    = 2'd0;
  localparam logic [1:0] SPI_NEVER_OFF = 2'd1;
  localparam logic [1:0] SPI_NEVER_ON  = 2'd2;

  logic clk = 1'b0;
  logic aresetn, sys_en, ext_shutdown, lock_viol;
  logic integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob;
  logic spi_off = 1'b1; // Driven by the SPI stand in
  logic irq_ack = 1'b0; // Driven by the processor stand in
  logic [7:0] shutdown_sense, over_thresh, thresh_underflow, thresh_overflow;
  logic [7:0] dac_boot_fail, adc_boot_fail, bad_dac_cmd, bad_adc_cmd;
  logic unlock_cfg, spi_clk_power_n, spi_en, shutdown_sense_en, block_buffers;
  logic n_shutdown_force, n_shutdown_rst, irq_req;
  logic [31:0] status_word;

  logic [1:0] spi_mode = SPI_NORMAL;
  int         spi_wake = 0;
  logic       req_q = 1'b0;
  int         req_rises = 0; // irq_req rising edges seen
  int         mismatches = 0;
  int         others = 0;    // Timeouts and file trouble
  int         scenarios = 0;

  // One scenario line
  logic [8*16-1:0]  kind;
  logic [8*256-1:0] line;
  logic [31:0] cfg_bits, sys_bits, sense_m, over_m, under_m, oflow_m;
  logic [31:0] dac_boot_m, adc_boot_m, bad_dac_m, bad_adc_m, exp_code, exp_board;

  hw_manager_top #(
    .SHUTDOWN_FORCE_DELAY (FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (RESET_DELAY),
    .SPI_RST_WAIT         (RST_WAIT),
    .SPI_START_WAIT       (START_WAIT)
  ) u_dut (.*);

  always #10 clk = ~clk; // 20 ns period

  // SPI subsystem reports on a few cycles after spi_en
  always @(posedge clk) begin
    case (spi_mode)
      SPI_NEVER_OFF: spi_off <= 1'b0;
      SPI_NEVER_ON:  spi_off <= 1'b1;
      default: begin
        if (!spi_en) begin
          spi_off  <= 1'b1;
          spi_wake <= 0;
        end else if (spi_wake == 5) spi_off <= 1'b0;
        else spi_wake <= spi_wake + 1;
      end
    endcase
  end

  always @(posedge clk) irq_ack <= irq_req; // Processor follows req one cycle late

  always @(posedge clk) begin
    req_q <= irq_req;
    if (irq_req && !req_q) req_rises <= req_rises + 1;
  end

  function automatic logic out_level(int sel);
    case (sel)
      SEL_FORCE:  return n_shutdown_force;
      SEL_RST:    return n_shutdown_rst;
      SEL_SPI_EN: return spi_en;
      SEL_BLOCK:  return block_buffers;
      SEL_REQ:    return irq_req;
      SEL_ACK:    return irq_ack;
      SEL_HALTED: return status_word[3:0] == ST_HALTED;
      default:    return status_word[3:0] == ST_IDLE;
    endcase
  endfunction

  // Board, code, state from high bits to low
  function automatic logic [31:0] word_of(logic [2:0] board, logic [24:0] code, logic [3:0] st);
    return {board, code, st};
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_level(int sel, logic level, string what);
    int n;
    n = 0;
    while (out_level(sel) !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (out_level(sel) !== level) begin
      others++;
      $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
    end
  endtask

  // Negedges on which the output still holds the level
  task automatic count_while(int sel, logic level, output int cycles);
    cycles = 0;
    while (out_level(sel) === level && cycles < WAIT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic wait_handshake();
    wait_level(SEL_REQ, 1'b1, "irq_req rising");
    wait_level(SEL_ACK, 1'b1, "irq_ack rising");
    check("irq_req at ack", irq_req, 1'b1); // Held until ack seen
    wait_level(SEL_REQ, 1'b0, "irq_req falling after ack");
    wait_level(SEL_ACK, 1'b0, "irq_ack falling");
  endtask

  task automatic start_sequence(logic [1:0] mode, logic with_cfg, logic with_boot);
    @(posedge clk);
    spi_mode <= mode;
    @(posedge clk);
    @(posedge clk); // Stand in has taken the new mode
    sys_en <= 1'b1;
    if (with_cfg) begin
      integ_thresh_avg_oob <= cfg_bits[0];
      integ_window_oob     <= cfg_bits[1];
      integ_en_oob         <= cfg_bits[2];
      sys_en_oob           <= cfg_bits[3];
    end
    if (with_boot) begin
      dac_boot_fail <= dac_boot_m[7:0];
      adc_boot_fail <= adc_boot_m[7:0];
    end
  endtask

  // Clean start up to running and phase lengths
  task automatic power_up();
    int cycles;
    int rises;
    rises = req_rises;
    start_sequence(SPI_NORMAL, 1'b0, 1'b0);
    wait_level(SEL_FORCE, 1'b1, "n_shutdown_force rising");
    count_while(SEL_RST, 1'b1, cycles);
    check("force release cycles", cycles, FORCE_DELAY + 1);
    count_while(SEL_RST, 1'b0, cycles);
    check("reset pulse cycles", cycles, RESET_PULSE + 1);
    count_while(SEL_SPI_EN, 1'b0, cycles);
    check("reset delay cycles", cycles, RESET_DELAY + 1);
    wait_level(SEL_BLOCK, 1'b0, "block_buffers falling");
    check("status_word", status_word, word_of(3'd0, CODE_OK, ST_RUNNING));
    check("n_shutdown_force", n_shutdown_force, 1'b1);
    check("spi_en", spi_en, 1'b1);
    check("spi_clk_power_n", spi_clk_power_n, 1'b0);
    check("shutdown_sense_en", shutdown_sense_en, 1'b1);
    check("unlock_cfg", unlock_cfg, 1'b0);
    wait_handshake();
    check("irq requests at run entry", req_rises - rises, 1);
  endtask

  task automatic check_halted();
    check("status_word", status_word, word_of(exp_board[2:0], exp_code[24:0], ST_HALTED));
    check("n_shutdown_force", n_shutdown_force, 1'b0);
    check("n_shutdown_rst", n_shutdown_rst, 1'b1);
    check("spi_en", spi_en, 1'b0);
    check("spi_clk_power_n", spi_clk_power_n, 1'b1);
    check("shutdown_sense_en", shutdown_sense_en, 1'b0);
    check("block_buffers", block_buffers, 1'b1);
    wait_handshake(); // Halt must raise irq_req
  endtask

  task automatic shut_down();
    @(posedge clk);
    sys_en               <= 1'b0;
    spi_mode             <= SPI_NORMAL;
    lock_viol            <= 1'b0;
    ext_shutdown         <= 1'b0;
    integ_thresh_avg_oob <= 1'b0;
    integ_window_oob     <= 1'b0;
    integ_en_oob         <= 1'b0;
    sys_en_oob           <= 1'b0;
    {shutdown_sense, over_thresh, thresh_underflow, thresh_overflow} <= '0;
    {dac_boot_fail, adc_boot_fail, bad_dac_cmd, bad_adc_cmd}         <= '0;
    wait_level(SEL_IDLE, 1'b1, "return to idle");
    check("status_word", status_word, word_of(3'd0, CODE_OK, ST_IDLE));
    check("unlock_cfg", unlock_cfg, 1'b1);
    wait_level(SEL_REQ, 1'b0, "irq_req quiet");
    wait_level(SEL_ACK, 1'b0, "irq_ack quiet");
  endtask

  task automatic run_scenario();
    if (kind == "clean") begin
      power_up();
    end else if (kind == "cfg") begin
      start_sequence(SPI_NORMAL, 1'b1, 1'b0);
      @(negedge clk);
      @(negedge clk); // Halt one edge after sys_en
      check("unlock_cfg", unlock_cfg, 1'b1);
      check_halted();
    end else if (kind == "run") begin
      power_up();
      @(posedge clk);
      lock_viol        <= sys_bits[0];
      ext_shutdown     <= sys_bits[1];
      if (sys_bits[2]) sys_en <= 1'b0;
      shutdown_sense   <= sense_m[7:0];
      over_thresh      <= over_m[7:0];
      thresh_underflow <= under_m[7:0];
      thresh_overflow  <= oflow_m[7:0];
      bad_dac_cmd      <= bad_dac_m[7:0];
      bad_adc_cmd      <= bad_adc_m[7:0];
      @(negedge clk);
      @(negedge clk); // Fault shows one edge later
      check_halted();
    end else if (kind == "spi_rst" || kind == "spi_start" || kind == "boot") begin
      start_sequence(kind == "spi_rst" ? SPI_NEVER_OFF : SPI_NEVER_ON, 1'b0, kind == "boot");
      wait_level(SEL_HALTED, 1'b1, "halt during start up");
      check_halted();
    end else begin
      others++;
      $display("Unknown scenario kind %0s in the scenario file", kind);
    end
    shut_down();
  endtask

  initial begin
    int fd;
    int n;
    aresetn              = 1'b0;
    sys_en               = 1'b0;
    ext_shutdown         = 1'b0;
    lock_viol            = 1'b0;
    integ_thresh_avg_oob = 1'b0;
    integ_window_oob     = 1'b0;
    integ_en_oob         = 1'b0;
    sys_en_oob           = 1'b0;
    {shutdown_sense, over_thresh, thresh_underflow, thresh_overflow} = '0;
    {dac_boot_fail, adc_boot_fail, bad_dac_cmd, bad_adc_cmd}         = '0;
    fd = $fopen("testbench/hw_manager_tests.txt", "r");
    if (fd == 0) begin
      others++;
      $display("Cannot open the scenario file testbench/hw_manager_tests.txt");
    end
    repeat (10) @(posedge clk);
    aresetn <= 1'b1;
    @(negedge clk);
    // Reset levels
    check("n_shutdown_force", n_shutdown_force, 1'b0);
    check("n_shutdown_rst", n_shutdown_rst, 1'b1);
    check("shutdown_sense_en", shutdown_sense_en, 1'b0);
    check("spi_en", spi_en, 1'b0);
    check("irq_req", irq_req, 1'b0);
    check("unlock_cfg", unlock_cfg, 1'b1);
    check("spi_clk_power_n", spi_clk_power_n, 1'b1);
    check("block_buffers", block_buffers, 1'b1);
    check("status_word", status_word, word_of(3'd0, CODE_OK, ST_IDLE));
    while (fd != 0) begin
      n = $fscanf(fd, " %s", kind);
      if (n != 1) break;
      if (kind == "#") begin // Comment line
        n = $fgets(line, fd);
        continue;
      end
      n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h", cfg_bits, sys_bits, sense_m,
                  over_m, under_m, oflow_m, dac_boot_m, adc_boot_m, bad_dac_m, bad_adc_m,
                  exp_code, exp_board);
      if (n != 12) begin
        others++;
        $display("Scenario line of kind %0s has missing fields", kind);
        break;
      end
      scenarios++;
      run_scenario();
    end
    if (fd != 0) $fclose(fd);
    if (scenarios == 0) begin
      others++;
      $display("No scenario was run");
    end
    $display("Summary: %0d scenarios, %0d mismatches, %0d other errors",
             scenarios, mismatches, others);
    if (mismatches == 0 && others == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
